// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= tb_snooper
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

# A $fatal in the testbench makes the simulation binary exit non-zero
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== testbench/snooper_patterns.txt ====
# C en mode clr | T count pc_src pc_dst metadata opcode | R addr data | P ptr addr
# All values hex; T adds the record index to every field of its burst
# After reset
R 000 00000000
R 004 00000000
P 0 008
P 0 00c
P 0 010
# Address mode, three records into rows 0 to 2
C 1 0 0
T 3 1111111100000000 2222222200000010 33330000 44440000
R 400 00000000
R 404 11111111
R 408 00000010
R 40c 22222222
R 410 33330000
R 420 00000001
R 42c 22222222
R 430 33330001
R 440 00000002
R 448 00000012
R 450 33330002
R 000 00000001
R 004 00000000
P 3 010
P 2 00c
P 0 008
# Instruction mode after a clear, opcodes go to bank 0 of rows 0 and 1
C 1 1 1
T 2 9999999900000000 9999999900000000 99990000 aaaa0000
R 000 00000003
P 2 010
P 1 00c
R 400 aaaa0000
R 420 aaaa0001
R 404 11111111
R 424 11111111
R 408 00000010
R 430 33330001
R 440 00000002
# Wrap-around, 18 records after a clear
C 1 0 1
T 12 5555555500000000 6666666600000100 77770000 88880000
R 004 00000001
P 2 010
P 2 008
P 1 00c
R 400 00000010
R 404 55555555
R 408 00000110
R 40c 66666666
R 410 77770010
R 420 00000011
R 430 77770011
R 5e0 0000000f
R 5f0 7777000f
# Clear zeroes the pointers and the full flag
C 1 0 1
R 000 00000001
R 004 00000000
P 0 010
P 0 008
P 0 00c
# Snooping disabled, pointers and contents stay as they are
C 0 0 0
T 3 bbbbbbbb00000000 cccccccc00000000 dddd0000 eeee0000
R 000 00000000
P 0 010
P 0 00c
R 400 00000010
R 404 55555555
R 410 77770010

// ==== testbench/tb_snooper.sv ====
/* Pattern-driven testbench for the snooper top level. Reads command lines
   from the pattern file, drives APB and trace traffic and checks readback. */
`timescale 1ns/1ps
`default_nettype none

`include "snooper_defines.svh"

module tb_snooper
   import snooper_pkg::*;
();

   localparam int apb_timeout = 16;

   logic                   clk;
   logic                   rst_n;
   logic [`SNP_APB_AW-1:0] paddr;
   logic                   psel;
   logic                   penable;
   logic                   pwrite;
   word_t                  pwdata;
   word_t                  prdata;
   logic                   pready;
   logic                   pslverr;
   logic                   trace_valid;
   logic [63:0]            pc_src;
   logic [63:0]            pc_dst;
   word_t                  metadata;
   word_t                  opcode;

   snooper_top dut_i (
      .clk_i         (clk),
      .rst_ni        (rst_n),
      .paddr_i       (paddr),
      .psel_i        (psel),
      .penable_i     (penable),
      .pwrite_i      (pwrite),
      .pwdata_i      (pwdata),
      .prdata_o      (prdata),
      .pready_o      (pready),
      .pslverr_o     (pslverr),
      .trace_valid_i (trace_valid),
      .pc_src_i      (pc_src),
      .pc_dst_i      (pc_dst),
      .metadata_i    (metadata),
      .opcode_i      (opcode)
   );

   always #2 clk = ~clk;

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("** FAIL **");
      $fatal(1, "simulation stopped on error");
   endtask

   task automatic check_word(input string name, input word_t expected, input word_t actual);
      if (actual !== expected) begin
         abort_run($sformatf("MISMATCH at %0t: %s expected %h actual %h",
                             $time, name, expected, actual));
      end
   endtask

   task automatic check_ptr(input string name, input ptr_t expected, input ptr_t actual);
      if (actual !== expected) begin
         abort_run($sformatf("MISMATCH at %0t: %s expected %h actual %h",
                             $time, name, expected, actual));
      end
   endtask

   task automatic check_bit(input string name, input logic expected, input logic actual);
      if (actual !== expected) begin
         abort_run($sformatf("MISMATCH at %0t: %s expected %b actual %b",
                             $time, name, expected, actual));
      end
   endtask

   // One APB transfer of setup and access phases until pready
   task automatic apb_transfer(input logic write, input logic [`SNP_APB_AW-1:0] addr,
                               input word_t wdata, output word_t rdata);
      int waits;

      @(negedge clk);
      paddr   <= addr;
      pwrite  <= write;
      pwdata  <= wdata;
      psel    <= 1'b1;
      penable <= 1'b0;
      @(negedge clk);
      penable <= 1'b1;
      // Look at pready once the access-phase inputs have settled
      #1;
      waits = 0;
      while (pready !== 1'b1) begin
         if (waits == apb_timeout) begin
            abort_run($sformatf("APB transfer to address %h got no pready in %0d cycles",
                                addr, apb_timeout));
         end
         waits++;
         @(negedge clk);
         #1;
      end
      rdata = prdata;
      check_bit("pslverr_o", 1'b0, pslverr);
      @(posedge clk);
      @(negedge clk);
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   // Burst of records with each field offset by the record index
   task automatic drive_trace(input int count, input logic [63:0] src,
                              input logic [63:0] dst, input word_t meta, input word_t op);
      int gap;

      for (int i = 0; i < count; i++) begin
         gap = int'($urandom % 4);
         repeat (gap) begin
            @(negedge clk);
            trace_valid <= 1'b0;
         end
         @(negedge clk);
         trace_valid <= 1'b1;
         pc_src      <= src + 64'(i);
         pc_dst      <= dst + 64'(i);
         metadata    <= meta + word_t'(i);
         opcode      <= op + word_t'(i);
      end
      @(negedge clk);
      trace_valid <= 1'b0;
   endtask

   initial begin
      #200000;
      abort_run("simulation watchdog expired before the pattern file was done");
   end

   initial begin
      int          fd;
      int          n;
      int          line_no;
      string       line;
      string       name;
      word_t       v0;
      word_t       v1;
      word_t       v2;
      word_t       rd;
      logic [63:0] src;
      logic [63:0] dst;

      void'($urandom(32'hcbe6ce82));
      clk         = 1'b0;
      rst_n       = 1'b0;
      paddr       = '0;
      psel        = 1'b0;
      penable     = 1'b0;
      pwrite      = 1'b0;
      pwdata      = '0;
      trace_valid = 1'b0;
      pc_src      = '0;
      pc_dst      = '0;
      metadata    = '0;
      opcode      = '0;
      repeat (8) @(negedge clk);
      rst_n <= 1'b1;

      fd = $fopen("testbench/snooper_patterns.txt", "r");
      if (fd == 0) begin
         abort_run("could not open testbench/snooper_patterns.txt");
      end
      line_no = 0;
      while ($fgets(line, fd) != 0) begin
         line_no++;
         if (line.len() < 2 || line[0] == "#") begin
            continue;
         end
         case (line[0])
            "C": begin
               n = $sscanf(line, "C %h %h %h", v0, v1, v2);
               if (n != 3) begin
                  abort_run($sformatf("pattern line %0d is malformed", line_no));
               end
               apb_transfer(1'b1, `SNP_REG_CTRL, word_t'({v2[0], v1[0], v0[0]}), rd);
            end
            "T": begin
               n = $sscanf(line, "T %h %h %h %h %h", v0, src, dst, v1, v2);
               if (n != 5) begin
                  abort_run($sformatf("pattern line %0d is malformed", line_no));
               end
               drive_trace(int'(v0), src, dst, v1, v2);
            end
            "R": begin
               n = $sscanf(line, "R %h %h", v1, v0);
               if (n != 2) begin
                  abort_run($sformatf("pattern line %0d is malformed", line_no));
               end
               apb_transfer(1'b0, v1[`SNP_APB_AW-1:0], '0, rd);
               name = $sformatf("prdata_o[%h]", v1[`SNP_APB_AW-1:0]);
               check_word(name, v0, rd);
            end
            "P": begin
               n = $sscanf(line, "P %h %h", v0, v1);
               if (n != 2) begin
                  abort_run($sformatf("pattern line %0d is malformed", line_no));
               end
               apb_transfer(1'b0, v1[`SNP_APB_AW-1:0], '0, rd);
               name = $sformatf("prdata_o[%h]", v1[`SNP_APB_AW-1:0]);
               check_ptr(name, ptr_t'(v0), ptr_t'(rd));
               // Pointers are zero-extended to a full word
               check_word({name, " upper bits"}, '0, rd >> ptr_w);
            end
            default: begin
               abort_run($sformatf("pattern line %0d has an unknown command", line_no));
            end
         endcase
      end
      $fclose(fd);
      $display("** PASS **");
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+verilog
verilog/snooper_pkg.sv
verilog/trace_capture.sv
verilog/snooping_engine.sv
verilog/trace_buffer.sv
verilog/snooper_apb_regs.sv
verilog/snooper_top.sv
testbench/tb_snooper.sv

// ==== verilog/snooper_apb_regs.sv ====
/* APB slave of the snooper. Holds the control register, returns status
   and pointers, and reads the trace buffer with one wait state. */
`timescale 1ns/1ps
`default_nettype none

`include "snooper_defines.svh"

module snooper_apb_regs
   import snooper_pkg::*;
(
   input  wire logic                   clk_i,
   input  wire logic                   rst_ni,
   input  wire logic [`SNP_APB_AW-1:0] paddr_i,
   input  wire logic                   psel_i,
   input  wire logic                   penable_i,
   input  wire logic                   pwrite_i,
   input  word_t                       pwdata_i,
   output word_t                       prdata_o,
   output logic                        pready_o,
   output logic                        snoop_en_o,
   output trace_mode_e                 trace_mode_o,
   output logic                        ptr_clr_o,
   output logic                        buf_re_o,
   output ptr_t                        buf_raddr_o,
   output logic [2:0]                  buf_rbank_o,
   input  word_t                       buf_rdata_i,
   input  ptr_t                        wr_ptr_i,
   input  ptr_t                        first_valid_i,
   input  ptr_t                        last_valid_i,
   input  wire logic                   buf_full_i
);

   localparam logic [`SNP_APB_AW-1:0] buf_end =
      `SNP_BUF_BASE + `SNP_APB_AW'(`SNP_BUF_DEPTH * 32);

   logic                   access;
   logic                   in_buf;
   logic [`SNP_APB_AW-1:0] buf_off;
   logic                   ctrl_wr;
   logic                   rd_wait_q;

   logic                   snoop_en_q;
   trace_mode_e            mode_q;
   logic                   ptr_clr_q;

   assign access  = psel_i & penable_i;
   assign in_buf  = (paddr_i >= `SNP_BUF_BASE) && (paddr_i < buf_end);
   assign buf_off = paddr_i - `SNP_BUF_BASE;
   assign ctrl_wr = access & pwrite_i & (paddr_i == `SNP_REG_CTRL);

   // Row in bits 5 and up, field in bits 4:2
   assign buf_raddr_o = buf_off[5 +: ptr_w];
   assign buf_rbank_o = buf_off[4:2];

   // Buffer read launches in the first access cycle, data arrives in the second
   assign buf_re_o = access & ~pwrite_i & in_buf & ~rd_wait_q;
   assign pready_o = access & (pwrite_i | ~in_buf | rd_wait_q);

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         rd_wait_q  <= 1'b0;
         snoop_en_q <= 1'b0;
         mode_q     <= MODE_ADDRESS;
         ptr_clr_q  <= 1'b0;
      end else begin
         rd_wait_q <= buf_re_o;
         ptr_clr_q <= ctrl_wr & pwdata_i[2];
         if (ctrl_wr) begin
            snoop_en_q <= pwdata_i[0];
            mode_q     <= trace_mode_e'(pwdata_i[1]);
         end
      end
   end

   always_comb begin
      prdata_o = '0;
      if (in_buf) begin
         prdata_o = buf_rdata_i;
      end else begin
         case (paddr_i)
            `SNP_REG_CTRL:   prdata_o = word_t'({mode_q, snoop_en_q});
            `SNP_REG_STATUS: prdata_o = word_t'(buf_full_i);
            `SNP_REG_FIRST:  prdata_o = word_t'(first_valid_i);
            `SNP_REG_LAST:   prdata_o = word_t'(last_valid_i);
            `SNP_REG_WRPTR:  prdata_o = word_t'(wr_ptr_i);
            default:         prdata_o = '0;
         endcase
      end
   end

   assign snoop_en_o   = snoop_en_q;
   assign trace_mode_o = mode_q;
   assign ptr_clr_o    = ptr_clr_q;

endmodule

`default_nettype wire

// ==== verilog/snooper_defines.svh ====
/* Sizes and APB register offsets of the branch-trace snooper.
   Included by the package and by every module that needs a constant. */
`ifndef SNOOPER_DEFINES_SVH
`define SNOOPER_DEFINES_SVH

// Buffer geometry
`define SNP_NUM_FIELDS 5
`define SNP_BUF_DEPTH 16
`define SNP_DATA_W 32

// APB address map
`define SNP_APB_AW 12
`define SNP_REG_CTRL 12'h000
`define SNP_REG_STATUS 12'h004
`define SNP_REG_FIRST 12'h008
`define SNP_REG_LAST 12'h00C
`define SNP_REG_WRPTR 12'h010

// Buffer window with one row every 32 bytes
`define SNP_BUF_BASE 12'h400

`endif

// ==== verilog/snooper_pkg.sv ====
/* Types shared by the snooper blocks: buffer words, row pointers,
   the per-bank field vector and the trace mode. */
`default_nettype none

`include "snooper_defines.svh"

package snooper_pkg;

   // One word of a buffer bank
   typedef logic [`SNP_DATA_W-1:0] word_t;

   // Row index into the trace buffer
   localparam int unsigned ptr_w = $clog2(`SNP_BUF_DEPTH);
   typedef logic [ptr_w-1:0] ptr_t;

   // Index 0 is pc_src low, then pc_src high, pc_dst low, pc_dst high, metadata
   typedef word_t [`SNP_NUM_FIELDS-1:0] field_vec_t;

   typedef enum logic {
      MODE_ADDRESS = 1'b0,
      MODE_INSTR   = 1'b1
   } trace_mode_e;

endpackage

`default_nettype wire

// ==== verilog/snooper_top.sv ====
/* Top level of the branch-trace snooper. Connects the APB slave,
   the capture stage, the snooping engine and the trace buffer. */
`timescale 1ns/1ps
`default_nettype none

`include "snooper_defines.svh"

module snooper_top
   import snooper_pkg::*;
(
   input  wire logic                   clk_i,
   input  wire logic                   rst_ni,
   input  wire logic [`SNP_APB_AW-1:0] paddr_i,
   input  wire logic                   psel_i,
   input  wire logic                   penable_i,
   input  wire logic                   pwrite_i,
   input  word_t                       pwdata_i,
   output word_t                       prdata_o,
   output logic                        pready_o,
   output logic                        pslverr_o,
   input  wire logic                   trace_valid_i,
   input  wire logic [63:0]            pc_src_i,
   input  wire logic [63:0]            pc_dst_i,
   input  word_t                       metadata_i,
   input  word_t                       opcode_i
);

   logic                       snoop_en;
   trace_mode_e                trace_mode;
   logic                       ptr_clr;
   logic                       cap_valid;
   trace_mode_e                cap_mode;
   field_vec_t                 cap_fields;
   logic [`SNP_NUM_FIELDS-1:0] buf_we;
   ptr_t                       buf_waddr;
   field_vec_t                 buf_wdata;
   logic                       buf_re;
   ptr_t                       buf_raddr;
   logic [2:0]                 buf_rbank;
   word_t                      buf_rdata;
   ptr_t                       wr_ptr;
   ptr_t                       first_valid;
   ptr_t                       last_valid;
   logic                       buf_full;

   // No error responses on this slave
   assign pslverr_o = 1'b0;

   snooper_apb_regs u_apb_regs (
      .clk_i, .rst_ni, .paddr_i, .psel_i, .penable_i, .pwrite_i, .pwdata_i,
      .prdata_o, .pready_o,
      .snoop_en_o    (snoop_en),
      .trace_mode_o  (trace_mode),
      .ptr_clr_o     (ptr_clr),
      .buf_re_o      (buf_re),
      .buf_raddr_o   (buf_raddr),
      .buf_rbank_o   (buf_rbank),
      .buf_rdata_i   (buf_rdata),
      .wr_ptr_i      (wr_ptr),
      .first_valid_i (first_valid),
      .last_valid_i  (last_valid),
      .buf_full_i    (buf_full)
   );

   trace_capture u_capture (
      .clk_i, .rst_ni,
      .snoop_en_i    (snoop_en),
      .trace_mode_i  (trace_mode),
      .trace_valid_i, .pc_src_i, .pc_dst_i, .metadata_i, .opcode_i,
      .cap_valid_o   (cap_valid),
      .cap_mode_o    (cap_mode),
      .cap_fields_o  (cap_fields)
   );

   snooping_engine u_engine (
      .clk_i, .rst_ni,
      .cap_valid_i   (cap_valid),
      .cap_mode_i    (cap_mode),
      .cap_fields_i  (cap_fields),
      .ptr_clr_i     (ptr_clr),
      .buf_we_o      (buf_we),
      .buf_waddr_o   (buf_waddr),
      .buf_wdata_o   (buf_wdata),
      .wr_ptr_o      (wr_ptr),
      .first_valid_o (first_valid),
      .last_valid_o  (last_valid),
      .buf_full_o    (buf_full)
   );

   trace_buffer u_buffer (
      .clk_i, .rst_ni,
      .we_i          (buf_we),
      .waddr_i       (buf_waddr),
      .wdata_i       (buf_wdata),
      .raddr_i       (buf_raddr),
      .rbank_i       (buf_rbank),
      .re_i          (buf_re),
      .rdata_o       (buf_rdata)
   );

endmodule

`default_nettype wire

// ==== verilog/snooping_engine.sv ====
/* Snooping engine. Writes captured records into the circular trace
   buffer and tracks write pointer, wrap flag and the valid row range. */
`timescale 1ns/1ps
`default_nettype none

`include "snooper_defines.svh"

module snooping_engine
   import snooper_pkg::*;
(
   input  wire logic                        clk_i,
   input  wire logic                        rst_ni,
   input  wire logic                        cap_valid_i,
   input  trace_mode_e                      cap_mode_i,
   input  field_vec_t                       cap_fields_i,
   input  wire logic                        ptr_clr_i,
   output logic [`SNP_NUM_FIELDS-1:0]       buf_we_o,
   output ptr_t                             buf_waddr_o,
   output field_vec_t                       buf_wdata_o,
   output ptr_t                             wr_ptr_o,
   output ptr_t                             first_valid_o,
   output ptr_t                             last_valid_o,
   output logic                             buf_full_o
);

   localparam ptr_t last_row = ptr_t'(`SNP_BUF_DEPTH - 1);

   logic do_write;
   logic last_hit;
   ptr_t next_ptr;

   ptr_t wr_ptr_q;
   ptr_t first_valid_q;
   ptr_t last_valid_q;
   logic buf_full_q;

   // A clear on the same edge drops the record in flight
   assign do_write = cap_valid_i & ~ptr_clr_i;
   assign last_hit = (wr_ptr_q == last_row);
   assign next_ptr = last_hit ? '0 : wr_ptr_q + 1'b1;

   // Address mode fills every bank, instruction mode only bank 0
   always_comb begin
      buf_we_o = '0;
      if (do_write) begin
         if (cap_mode_i == MODE_INSTR) begin
            buf_we_o[0] = 1'b1;
         end else begin
            buf_we_o = '1;
         end
      end
   end

   assign buf_waddr_o = wr_ptr_q;
   assign buf_wdata_o = cap_fields_i;

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         wr_ptr_q      <= '0;
         first_valid_q <= '0;
         last_valid_q  <= '0;
         buf_full_q    <= 1'b0;
      end else if (ptr_clr_i) begin
         wr_ptr_q      <= '0;
         first_valid_q <= '0;
         last_valid_q  <= '0;
         buf_full_q    <= 1'b0;
      end else if (do_write) begin
         wr_ptr_q     <= next_ptr;
         last_valid_q <= wr_ptr_q;
         if (last_hit) begin
            buf_full_q <= 1'b1;
         end
         // Once wrapped, the oldest entry sits just past the newest
         if (buf_full_q || last_hit) begin
            first_valid_q <= next_ptr;
         end
      end
   end

   assign wr_ptr_o      = wr_ptr_q;
   assign first_valid_o = first_valid_q;
   assign last_valid_o  = last_valid_q;
   assign buf_full_o    = buf_full_q;

endmodule

`default_nettype wire

// ==== verilog/trace_buffer.sv ====
/* Banked trace memory, one bank per record field. Per-bank write
   enables and a single registered read port for the APB side. */
`timescale 1ns/1ps
`default_nettype none

`include "snooper_defines.svh"

module trace_buffer
   import snooper_pkg::*;
(
   input  wire logic                        clk_i,
   input  wire logic                        rst_ni,
   input  wire logic [`SNP_NUM_FIELDS-1:0]  we_i,
   input  ptr_t                             waddr_i,
   input  field_vec_t                       wdata_i,
   input  ptr_t                             raddr_i,
   input  wire logic [2:0]                  rbank_i,
   input  wire logic                        re_i,
   output word_t                            rdata_o
);

   word_t mem [`SNP_NUM_FIELDS][`SNP_BUF_DEPTH];

   always_ff @(posedge clk_i) begin
      for (int b = 0; b < `SNP_NUM_FIELDS; b++) begin
         if (we_i[b]) begin
            mem[b][waddr_i] <= wdata_i[b];
         end
      end
   end

   // Bank numbers past the last field read as zero
   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         rdata_o <= '0;
      end else if (re_i) begin
         if (rbank_i < 3'(`SNP_NUM_FIELDS)) begin
            rdata_o <= mem[rbank_i][raddr_i];
         end else begin
            rdata_o <= '0;
         end
      end
   end

endmodule

`default_nettype wire

// ==== verilog/trace_capture.sv ====
/* Capture stage of the snooper. Registers each accepted trace record
   together with its mode, already split into buffer fields. */
`timescale 1ns/1ps
`default_nettype none

module trace_capture
   import snooper_pkg::*;
(
   input  wire logic        clk_i,
   input  wire logic        rst_ni,
   input  wire logic        snoop_en_i,
   input  trace_mode_e      trace_mode_i,
   input  wire logic        trace_valid_i,
   input  wire logic [63:0] pc_src_i,
   input  wire logic [63:0] pc_dst_i,
   input  word_t            metadata_i,
   input  word_t            opcode_i,
   output logic             cap_valid_o,
   output trace_mode_e      cap_mode_o,
   output field_vec_t       cap_fields_o
);

   logic       accept;
   field_vec_t fields_d;

   assign accept = trace_valid_i & snoop_en_i;

   // Instruction mode keeps only the opcode, in bank 0
   always_comb begin
      fields_d = '0;
      if (trace_mode_i == MODE_INSTR) begin
         fields_d[0] = opcode_i;
      end else begin
         fields_d[0] = pc_src_i[31:0];
         fields_d[1] = pc_src_i[63:32];
         fields_d[2] = pc_dst_i[31:0];
         fields_d[3] = pc_dst_i[63:32];
         fields_d[4] = metadata_i;
      end
   end

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         cap_valid_o <= 1'b0;
         cap_mode_o  <= MODE_ADDRESS;
      end else begin
         cap_valid_o <= accept;
         if (accept) begin
            cap_mode_o <= trace_mode_i;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (accept) begin
         cap_fields_o <= fields_d;
      end
   end

endmodule

`default_nettype wire
